// ==== vlog.f ====
+incdir+.
rv_decode_pkg.sv
predictor_pkg.sv
predictor_update_if.sv
branch_history_table.sv
jalr_target_table.sv
slot_decoder.sv
redirect_select.sv
jump_controller_top.sv
tb_jump_controller.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_jump_controller
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
FILELIST  ?= vlog.f

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := jump_ctrl_settings.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source, the header or the file list changes
$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "^Testbench passed$$"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_jump_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "jump_ctrl_settings.svh"

module tb_jump_controller;

	typedef logic [`XLEN-1:0] word_t;

	localparam int PERIOD = 20;
	localparam int CYCLES = 200;  // Per test
	localparam int NUM_TESTS = 6;
	localparam int WATCHDOG_CYCLES = NUM_TESTS * CYCLES + 8 + 100;
	localparam int TAG_LSB = `PC_IDX_LSB + `JALR_IDX_BITS;

	logic clk;
	logic rst_n;
	logic jalr_prediction_valid;
	logic redirect_valid;
	word_t current_pc [`FETCH_WIDTH];
	word_t instruction [`FETCH_WIDTH];
	logic br_update_valid [`UPDATE_PORTS];
	word_t br_update_pc [`UPDATE_PORTS];
	logic br_mispredict [`UPDATE_PORTS];
	logic jalr_update_valid [`UPDATE_PORTS];
	word_t jalr_update_pc [`UPDATE_PORTS];
	logic jalr_mispredict [`UPDATE_PORTS];
	word_t jalr_correct_pc [`UPDATE_PORTS];
	logic jump [`FETCH_WIDTH];
	logic jalr [`FETCH_WIDTH];
	word_t jalr_prediction_target;
	word_t redirect_target;
	logic [`SLOT_IDX_BITS-1:0] redirect_slot;

	// Reference model state
	int ctr_m [`BHT_ENTRIES];       // 0 strong not taken up to 3 strong taken
	logic jv_m [`JALR_ENTRIES];
	word_t jpc_m [`JALR_ENTRIES];   // Training PC whose upper bits give the tag
	word_t jtgt_m [`JALR_ENTRIES];
	int kind_m [`FETCH_WIDTH];      // 0 other, 1 JAL, 2 branch, 3 JALR
	word_t imm_m [`FETCH_WIDTH];

	integer seed = 58548;
	int errors = 0;
	int checks = 0;
	int test_errors;

	jump_controller_top UUT (.*);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_CYCLES * PERIOD);
		$display("Watchdog expired, the tests did not finish in time");
		$display("Testbench failed");
		$finish;
	end

	//////////////////////////////
	// Stimulus helpers
	//////////////////////////////

	function automatic int rnd(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	// Two tag regions of 32 words each so updates alias lookups
	function automatic word_t pick_pc();
		word_t base;
		base = (rnd(2) == 0) ? 32'h0000_1000 : 32'h0040_1000;
		return base + (word_t'(rnd(32)) << 2);
	endfunction

	function automatic int pick_kind(input int mode);
		case (mode)
			1: return 1 + rnd(2);  // JAL and branch only
			2: return 1 + rnd(3);
			3: return 3;
			default: return rnd(4);
		endcase
	endfunction

	// Builds the instruction from a chosen immediate
	task automatic set_slot(input int f, input int kind);
		word_t r;
		logic [20:0] imm;
		logic [6:0] op;
		r = $random(seed);
		imm = {r[20:1], 1'b0};
		current_pc[f] = pick_pc();
		kind_m[f] = kind;
		imm_m[f] = '0;
		op = r[6:0];
		if (op == 7'b1101111 || op == 7'b1100011 || op == 7'b1100111) begin
			op[4] = ~op[4];  // Keep it a non-control opcode
		end
		case (kind)
			1: begin
				imm_m[f] = {{11{imm[20]}}, imm};
				instruction[f] = {imm[20], imm[10:1], imm[11], imm[19:12], r[11:7], 7'b1101111};
			end
			2: begin
				imm_m[f] = {{19{imm[12]}}, imm[12:0]};
				instruction[f] = {imm[12], imm[10:5], r[31:19], imm[4:1], imm[11], 7'b1100011};
			end
			3: instruction[f] = {r[31:7], 7'b1100111};
			default: instruction[f] = {r[31:7], op};
		endcase
	endtask

	task automatic drive_updates(input int br_pct, input int jalr_pct, input bit same_pc);
		word_t shared;
		shared = pick_pc();
		for (int p = 0; p < `UPDATE_PORTS; p++) begin
			br_update_valid[p] = rnd(100) < br_pct;
			br_update_pc[p] = same_pc ? shared : pick_pc();
			br_mispredict[p] = rnd(2) == 1;
			jalr_update_valid[p] = rnd(100) < jalr_pct;
			jalr_update_pc[p] = same_pc ? shared : pick_pc();
			jalr_mispredict[p] = rnd(2) == 1;
			jalr_correct_pc[p] = $random(seed) & 32'hffff_fffc;
		end
	endtask

	//////////////////////////////
	// Reference model
	//////////////////////////////

	task automatic model_reset();
		for (int e = 0; e < `BHT_ENTRIES; e++) begin
			ctr_m[e] = 1;  // Weakly not taken
		end
		for (int e = 0; e < `JALR_ENTRIES; e++) begin
			jv_m[e] = 1'b0;
		end
	endtask

	// State after the coming rising edge with ports applied in order
	task automatic model_edge();
		int idx;
		logic outcome;
		if (!rst_n) begin
			model_reset();
		end else begin
			for (int p = 0; p < `UPDATE_PORTS; p++) begin
				if (br_update_valid[p]) begin
					idx = int'(br_update_pc[p][`PC_IDX_LSB +: `BHT_IDX_BITS]);
					outcome = (ctr_m[idx] >= 2) ^ br_mispredict[p];
					if (outcome && ctr_m[idx] < 3) begin
						ctr_m[idx]++;
					end else if (!outcome && ctr_m[idx] > 0) begin
						ctr_m[idx]--;
					end
				end
				if (jalr_update_valid[p] && jalr_mispredict[p]) begin
					idx = int'(jalr_update_pc[p][`PC_IDX_LSB +: `JALR_IDX_BITS]);
					jv_m[idx] = 1'b1;
					jpc_m[idx] = jalr_update_pc[p];
					jtgt_m[idx] = jalr_correct_pc[p];
				end
			end
		end
	endtask

	task automatic compare(input string name, input word_t expected, input word_t actual);
		checks++;
		assert (actual === expected) else begin
			$display("MISMATCH at %0t: %s expected %h, got %h", $time, name, expected, actual);
			errors++;
			test_errors++;
		end
	endtask

	task automatic check_outputs();
		logic hit [`FETCH_WIDTH];
		logic exp_jump [`FETCH_WIDTH];
		word_t tgt [`FETCH_WIDTH];
		int e;
		int first_jalr;
		int first_redir;
		first_jalr = -1;
		first_redir = -1;
		for (int f = 0; f < `FETCH_WIDTH; f++) begin
			e = int'(current_pc[f][`PC_IDX_LSB +: `JALR_IDX_BITS]);
			hit[f] = kind_m[f] == 3 && jv_m[e] &&
				jpc_m[e][`XLEN-1:TAG_LSB] == current_pc[f][`XLEN-1:TAG_LSB];
			tgt[f] = (kind_m[f] == 3) ? jtgt_m[e] : current_pc[f] + imm_m[f];
			e = int'(current_pc[f][`PC_IDX_LSB +: `BHT_IDX_BITS]);
			exp_jump[f] = kind_m[f] == 1 || (kind_m[f] == 2 && ctr_m[e] >= 2);
			if (first_jalr < 0 && kind_m[f] == 3) begin
				first_jalr = f;
			end
			if (first_redir < 0 && (exp_jump[f] || hit[f])) begin
				first_redir = f;
			end
			compare($sformatf("jump[%0d]", f), word_t'(exp_jump[f]), word_t'(jump[f]));
			compare($sformatf("jalr[%0d]", f), word_t'(kind_m[f] == 3), word_t'(jalr[f]));
		end
		if (first_jalr >= 0 && hit[first_jalr]) begin
			compare("jalr_prediction_valid", 1, word_t'(jalr_prediction_valid));
			compare("jalr_prediction_target", tgt[first_jalr], jalr_prediction_target);
		end else begin
			compare("jalr_prediction_valid", 0, word_t'(jalr_prediction_valid));
		end
		compare("redirect_valid", word_t'(first_redir >= 0), word_t'(redirect_valid));
		if (first_redir >= 0) begin
			compare("redirect_slot", word_t'(first_redir), word_t'(redirect_slot));
			compare("redirect_target", tgt[first_redir], redirect_target);
		end
	endtask

	// Updates stop after a mid-run reset so the post-reset state is seen
	task automatic run_test(input string name, input int mode, input int br_pct,
		input int jalr_pct, input bit same_pc, input int reset_at);
		test_errors = 0;
		for (int c = 0; c < CYCLES; c++) begin
			@(negedge clk);
			rst_n = (c != reset_at);
			for (int f = 0; f < `FETCH_WIDTH; f++) begin
				set_slot(f, pick_kind(mode));
			end
			if (reset_at >= 0 && c >= reset_at) begin
				drive_updates(0, 0, 1'b0);
			end else begin
				drive_updates(br_pct, jalr_pct, same_pc && rnd(2) == 1);
			end
			#(PERIOD / 2 - 1);  // Just before the rising edge
			check_outputs();
			model_edge();
		end
		$display("%-22s %0d cycles, %0d errors", name, CYCLES, test_errors);
	endtask

	initial begin
		rst_n = 1'b0;
		for (int f = 0; f < `FETCH_WIDTH; f++) begin
			current_pc[f] = '0;
			instruction[f] = '0;
		end
		drive_updates(0, 0, 1'b0);
		model_reset();
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		run_test("after_reset", 0, 0, 0, 1'b0, -1);
		run_test("direct_targets", 1, 60, 0, 1'b0, -1);
		run_test("counter_training", 1, 100, 0, 1'b1, -1);
		run_test("jalr_table", 3, 0, 80, 1'b1, -1);
		run_test("priority", 2, 50, 50, 1'b0, -1);
		run_test("reset_after_training", 0, 60, 60, 1'b0, CYCLES / 2);
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== jump_controller_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "jump_ctrl_settings.svh"

module jump_controller_top (
	input  logic                      clk,
	input  logic                      rst_n,

	// Fetch group
	input  logic [`XLEN-1:0]          current_pc [`FETCH_WIDTH],
	input  logic [`XLEN-1:0]          instruction [`FETCH_WIDTH],

	// Branch training, one per execute unit
	input  logic                      br_update_valid [`UPDATE_PORTS],
	input  logic [`XLEN-1:0]          br_update_pc [`UPDATE_PORTS],
	input  logic                      br_mispredict [`UPDATE_PORTS],

	// JALR training
	input  logic                      jalr_update_valid [`UPDATE_PORTS],
	input  logic [`XLEN-1:0]          jalr_update_pc [`UPDATE_PORTS],
	input  logic                      jalr_mispredict [`UPDATE_PORTS],
	input  logic [`XLEN-1:0]          jalr_correct_pc [`UPDATE_PORTS],

	// Decisions
	output logic                      jump [`FETCH_WIDTH],
	output logic                      jalr [`FETCH_WIDTH],
	output logic                      jalr_prediction_valid,
	output logic [`XLEN-1:0]          jalr_prediction_target,
	output logic                      redirect_valid,
	output logic [`SLOT_IDX_BITS-1:0] redirect_slot,
	output logic [`XLEN-1:0]          redirect_target
);

	predictor_update_if br_upd   [`UPDATE_PORTS] ();
	predictor_update_if jalr_upd [`UPDATE_PORTS] ();
	slot_result_if      slot_res [`FETCH_WIDTH] ();

	logic                      bht_taken  [`FETCH_WIDTH];
	logic                      jtt_hit    [`FETCH_WIDTH];
	logic [`XLEN-1:0]          jtt_target [`FETCH_WIDTH];
	logic                      slot_jalr_hit [`FETCH_WIDTH];
	rv_decode_pkg::slot_kind_e slot_kind  [`FETCH_WIDTH];

	//////////////////////////////
	// Training ports
	//////////////////////////////

	for (genvar p = 0; p < `UPDATE_PORTS; p++) begin : g_upd
		assign br_upd[p].valid      = br_update_valid[p];
		assign br_upd[p].pc         = br_update_pc[p];
		assign br_upd[p].mispredict = br_mispredict[p];
		assign br_upd[p].correct_pc = '0; // Counters need no target

		assign jalr_upd[p].valid      = jalr_update_valid[p];
		assign jalr_upd[p].pc         = jalr_update_pc[p];
		assign jalr_upd[p].mispredict = jalr_mispredict[p];
		assign jalr_upd[p].correct_pc = jalr_correct_pc[p];
	end

	branch_history_table u_bht (
		.clk       (clk),
		.rst_n     (rst_n),
		.lookup_pc (current_pc),
		.upd       (br_upd),
		.taken     (bht_taken)
	);

	jalr_target_table u_jtt (
		.clk       (clk),
		.rst_n     (rst_n),
		.lookup_pc (current_pc),
		.upd       (jalr_upd),
		.hit       (jtt_hit),
		.target    (jtt_target)
	);

	//////////////////////////////
	// Slot decode
	//////////////////////////////

	for (genvar f = 0; f < `FETCH_WIDTH; f++) begin : g_slot
		// Table hit only counts on a JALR slot
		assign slot_jalr_hit[f] = jtt_hit[f] && (slot_kind[f] == rv_decode_pkg::KIND_JALR);

		slot_decoder u_dec (
			.pc          (current_pc[f]),
			.instruction (instruction[f]),
			.taken       (bht_taken[f]),
			.jalr_hit    (slot_jalr_hit[f]),
			.jalr_target (jtt_target[f]),
			.kind        (slot_kind[f]),
			.res         (slot_res[f])
		);
	end

	redirect_select u_sel (
		.slots                  (slot_res),
		.jump                   (jump),
		.jalr                   (jalr),
		.jalr_prediction_valid  (jalr_prediction_valid),
		.jalr_prediction_target (jalr_prediction_target),
		.redirect_valid         (redirect_valid),
		.redirect_slot          (redirect_slot),
		.redirect_target        (redirect_target)
	);

endmodule

`default_nettype wire

// ==== redirect_select.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "jump_ctrl_settings.svh"

module redirect_select (
	slot_result_if.dst               slots [`FETCH_WIDTH],
	output logic                     jump [`FETCH_WIDTH],
	output logic                     jalr [`FETCH_WIDTH],
	output logic                     jalr_prediction_valid,
	output logic [`XLEN-1:0]         jalr_prediction_target,
	output logic                     redirect_valid,
	output logic [`SLOT_IDX_BITS-1:0] redirect_slot,
	output logic [`XLEN-1:0]         redirect_target
);

	logic             jalr_hit    [`FETCH_WIDTH];
	logic [`XLEN-1:0] direct_tgt  [`FETCH_WIDTH];
	logic [`XLEN-1:0] jalr_tgt    [`FETCH_WIDTH];

	// Per-slot fan-out
	for (genvar f = 0; f < `FETCH_WIDTH; f++) begin : g_slot
		assign jump[f]       = slots[f].jump;
		assign jalr[f]       = slots[f].kind == rv_decode_pkg::KIND_JALR;
		assign jalr_hit[f]   = slots[f].jalr_hit;
		assign direct_tgt[f] = slots[f].direct_target;
		assign jalr_tgt[f]   = slots[f].jalr_target;
	end

	//////////////////////////////
	// Priority picks
	//////////////////////////////

	// Walk from the last slot down so the lowest one wins
	always_comb begin
		jalr_prediction_valid  = 1'b0;
		jalr_prediction_target = '0;
		for (int f = `FETCH_WIDTH - 1; f >= 0; f--) begin
			if (jalr[f]) begin
				jalr_prediction_valid  = jalr_hit[f];
				jalr_prediction_target = jalr_tgt[f];
			end
		end
	end

	always_comb begin
		redirect_valid  = 1'b0;
		redirect_slot   = '0;
		redirect_target = '0;
		for (int f = `FETCH_WIDTH - 1; f >= 0; f--) begin
			if (jump[f] || jalr_hit[f]) begin
				redirect_valid  = 1'b1;
				redirect_slot   = f[`SLOT_IDX_BITS-1:0];
				redirect_target = jalr[f] ? jalr_tgt[f] : direct_tgt[f];
			end
		end
	end

endmodule

`default_nettype wire

// ==== slot_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "jump_ctrl_settings.svh"

module slot_decoder (
	input  logic                      [`XLEN-1:0] pc,
	input  logic                      [`XLEN-1:0] instruction,
	input  logic                      taken,
	input  logic                      jalr_hit,
	input  logic                      [`XLEN-1:0] jalr_target,
	output rv_decode_pkg::slot_kind_e kind,
	slot_result_if.src                res
);

	logic [rv_decode_pkg::J_IMM_W-1:0] j_imm;
	logic [rv_decode_pkg::B_IMM_W-1:0] b_imm;
	logic [`XLEN-1:0]                  imm;
	logic                              sign;

	// Opcode class
	always_comb begin
		case (instruction[rv_decode_pkg::OPCODE_W-1:0])
			rv_decode_pkg::OP_JAL:    kind = rv_decode_pkg::KIND_JAL;
			rv_decode_pkg::OP_BRANCH: kind = rv_decode_pkg::KIND_BRANCH;
			rv_decode_pkg::OP_JALR:   kind = rv_decode_pkg::KIND_JALR;
			default:                  kind = rv_decode_pkg::KIND_OTHER;
		endcase
	end

	// Scrambled immediate fields back into order
	assign sign  = instruction[rv_decode_pkg::SIGN_BIT];
	assign j_imm = {sign, instruction[19:12], instruction[20], instruction[30:21], 1'b0};
	assign b_imm = {sign, instruction[7], instruction[30:25], instruction[11:8], 1'b0};

	always_comb begin
		if (kind == rv_decode_pkg::KIND_JAL) begin
			imm = {{(`XLEN - rv_decode_pkg::J_IMM_W){sign}}, j_imm};
		end else begin
			imm = {{(`XLEN - rv_decode_pkg::B_IMM_W){sign}}, b_imm};
		end
	end

	assign res.kind          = kind;
	assign res.jump          = (kind == rv_decode_pkg::KIND_JAL) ||
		((kind == rv_decode_pkg::KIND_BRANCH) && taken);
	assign res.direct_target = pc + imm; // Meaningless for JALR and others
	assign res.jalr_hit      = (kind == rv_decode_pkg::KIND_JALR) && jalr_hit;
	assign res.jalr_target   = jalr_target;

endmodule

`default_nettype wire

// ==== jalr_target_table.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "jump_ctrl_settings.svh"

module jalr_target_table (
	input  logic             clk,
	input  logic             rst_n,
	input  logic [`XLEN-1:0] lookup_pc [`FETCH_WIDTH],
	predictor_update_if.dst  upd [`UPDATE_PORTS],
	output logic             hit [`FETCH_WIDTH],
	output logic [`XLEN-1:0] target [`FETCH_WIDTH]
);

	predictor_pkg::jalr_entry_t entry      [`JALR_ENTRIES];
	predictor_pkg::jalr_entry_t entry_next [`JALR_ENTRIES];

	logic                                upd_write   [`UPDATE_PORTS];
	logic [`JALR_IDX_BITS-1:0]           upd_idx     [`UPDATE_PORTS];
	logic [predictor_pkg::JALR_TAG_W-1:0] upd_tag    [`UPDATE_PORTS];
	logic [`XLEN-1:0]                    upd_target  [`UPDATE_PORTS];

	//////////////////////////////
	// Training
	//////////////////////////////

	for (genvar p = 0; p < `UPDATE_PORTS; p++) begin : g_upd
		assign upd_write[p]  = upd[p].valid && upd[p].mispredict; // Correct guesses leave it be
		assign upd_idx[p]    = upd[p].pc[`PC_IDX_LSB +: `JALR_IDX_BITS];
		assign upd_tag[p]    = upd[p].pc[`XLEN-1 -: predictor_pkg::JALR_TAG_W];
		assign upd_target[p] = upd[p].correct_pc;
	end

	always_comb begin
		entry_next = entry;
		for (int p = 0; p < `UPDATE_PORTS; p++) begin
			if (upd_write[p]) begin
				entry_next[upd_idx[p]] = '{valid: 1'b1, tag: upd_tag[p], target: upd_target[p]};
			end
		end
	end

	// Only the valid bits see reset
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int e = 0; e < `JALR_ENTRIES; e++) begin
				entry[e].valid <= 1'b0;
			end
		end else begin
			entry <= entry_next;
		end
	end

	//////////////////////////////
	// Lookup
	//////////////////////////////

	for (genvar f = 0; f < `FETCH_WIDTH; f++) begin : g_lookup
		predictor_pkg::jalr_entry_t rd;

		assign rd = entry[lookup_pc[f][`PC_IDX_LSB +: `JALR_IDX_BITS]];
		assign hit[f] = rd.valid &&
			(rd.tag == lookup_pc[f][`XLEN-1 -: predictor_pkg::JALR_TAG_W]);
		assign target[f] = hit[f] ? rd.target : '0; // Zero on a miss
	end

endmodule

`default_nettype wire

// ==== branch_history_table.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "jump_ctrl_settings.svh"

module branch_history_table (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic [`XLEN-1:0]       lookup_pc [`FETCH_WIDTH],
	predictor_update_if.dst        upd [`UPDATE_PORTS],
	output logic                   taken [`FETCH_WIDTH]
);

	predictor_pkg::ctr_state_e ctr      [`BHT_ENTRIES];
	predictor_pkg::ctr_state_e ctr_next [`BHT_ENTRIES];

	logic                     upd_valid      [`UPDATE_PORTS];
	logic [`BHT_IDX_BITS-1:0] upd_idx        [`UPDATE_PORTS];
	logic                     upd_mispredict [`UPDATE_PORTS];

	function automatic logic is_taken(input predictor_pkg::ctr_state_e cur);
		return (cur == predictor_pkg::WEAK_T) || (cur == predictor_pkg::STRONG_T);
	endfunction

	// One saturating step toward the resolved outcome
	function automatic predictor_pkg::ctr_state_e step_ctr(
		input predictor_pkg::ctr_state_e cur,
		input logic                      mispredict
	);
		logic outcome;
		predictor_pkg::ctr_state_e nxt;
		outcome = is_taken(cur) ^ mispredict; // Prediction was wrong, flip it
		case (cur)
			predictor_pkg::STRONG_NT: nxt = outcome ? predictor_pkg::WEAK_NT : predictor_pkg::STRONG_NT;
			predictor_pkg::WEAK_NT:   nxt = outcome ? predictor_pkg::WEAK_T : predictor_pkg::STRONG_NT;
			predictor_pkg::WEAK_T:    nxt = outcome ? predictor_pkg::STRONG_T : predictor_pkg::WEAK_NT;
			default:                  nxt = outcome ? predictor_pkg::STRONG_T : predictor_pkg::WEAK_T;
		endcase
		return nxt;
	endfunction

	//////////////////////////////
	// Update ports
	//////////////////////////////

	for (genvar p = 0; p < `UPDATE_PORTS; p++) begin : g_upd
		assign upd_valid[p]      = upd[p].valid;
		assign upd_idx[p]        = upd[p].pc[`PC_IDX_LSB +: `BHT_IDX_BITS];
		assign upd_mispredict[p] = upd[p].mispredict;
	end

	// Ports chain in order, so same-index updates stack
	always_comb begin
		ctr_next = ctr;
		for (int p = 0; p < `UPDATE_PORTS; p++) begin
			if (upd_valid[p]) begin
				ctr_next[upd_idx[p]] = step_ctr(ctr_next[upd_idx[p]], upd_mispredict[p]);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int e = 0; e < `BHT_ENTRIES; e++) begin
				ctr[e] <= predictor_pkg::WEAK_NT;
			end
		end else begin
			ctr <= ctr_next;
		end
	end

	//////////////////////////////
	// Lookup
	//////////////////////////////

	for (genvar f = 0; f < `FETCH_WIDTH; f++) begin : g_lookup
		assign taken[f] = is_taken(ctr[lookup_pc[f][`PC_IDX_LSB +: `BHT_IDX_BITS]]);
	end

endmodule

`default_nettype wire

// ==== predictor_update_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "jump_ctrl_settings.svh"

// One execute unit's training strobe
interface predictor_update_if;
	logic             valid;
	logic [`XLEN-1:0] pc;
	logic             mispredict;
	logic [`XLEN-1:0] correct_pc; // Only the JALR table reads this

	modport src (output valid, output pc, output mispredict, output correct_pc);
	modport dst (input valid, input pc, input mispredict, input correct_pc);
endinterface

// Decoded slot, from slot_decoder to redirect_select
interface slot_result_if;
	rv_decode_pkg::slot_kind_e kind;
	logic                      jump;          // JAL or predicted-taken branch
	logic [`XLEN-1:0]          direct_target;
	logic                      jalr_hit;
	logic [`XLEN-1:0]          jalr_target;

	modport src (output kind, output jump, output direct_target, output jalr_hit,
		output jalr_target);
	modport dst (input kind, input jump, input direct_target, input jalr_hit,
		input jalr_target);
endinterface

`default_nettype wire

// ==== predictor_pkg.sv ====
`default_nettype none

`include "jump_ctrl_settings.svh"

package predictor_pkg;

	// 2-bit saturating counter, upper half predicts taken
	typedef enum logic [1:0] {
		STRONG_NT = 2'b00,
		WEAK_NT   = 2'b01,
		WEAK_T    = 2'b10,
		STRONG_T  = 2'b11
	} ctr_state_e;

	// Everything above the index bits goes into the tag
	localparam int JALR_TAG_W = `XLEN - `PC_IDX_LSB - `JALR_IDX_BITS;

	typedef struct packed {
		logic                  valid;
		logic [JALR_TAG_W-1:0] tag;
		logic [`XLEN-1:0]      target;
	} jalr_entry_t;

endpackage

`default_nettype wire

// ==== rv_decode_pkg.sv ====
`default_nettype none

package rv_decode_pkg;

	//////////////////////////////
	// Instruction fields
	//////////////////////////////

	localparam int OPCODE_W = 7;
	localparam int SIGN_BIT = 31; // Sign of every immediate format

	// J-type imm[20:1] and B-type imm[12:1], bit 0 implied zero
	localparam int J_IMM_W = 21;
	localparam int B_IMM_W = 13;

	//////////////////////////////
	// Control transfer opcodes
	//////////////////////////////

	typedef enum logic [OPCODE_W-1:0] {
		OP_JAL    = 7'b1101111,
		OP_BRANCH = 7'b1100011,
		OP_JALR   = 7'b1100111
	} opcode_e;

	// Per-slot class after decode
	typedef enum logic [1:0] {
		KIND_OTHER  = 2'd0,
		KIND_JAL    = 2'd1,
		KIND_BRANCH = 2'd2,
		KIND_JALR   = 2'd3
	} slot_kind_e;

endpackage

`default_nettype wire

// ==== jump_ctrl_settings.svh ====
`ifndef JUMP_CTRL_SETTINGS_SVH
`define JUMP_CTRL_SETTINGS_SVH

// Datapath
`define XLEN          32
`define FETCH_WIDTH   5
`define SLOT_IDX_BITS 3  // Enough to number FETCH_WIDTH slots

// Execute units feeding training updates
`define UPDATE_PORTS  3

// Both tables drop the two byte offset bits of the PC
`define PC_IDX_LSB    2

`define BHT_ENTRIES   32
`define BHT_IDX_BITS  5  // PC bits 6 to 2

`define JALR_ENTRIES  16
`define JALR_IDX_BITS 4  // PC bits 5 to 2, tag is everything above

`endif
